// File: hdl/rv64ExecPkg.sv
package rv64ExecPkg;

    // register value, operand or result
    typedef logic [63:0] wordT;

    // raw instruction word
    typedef logic [31:0] instrT;

    // major opcode, instr[6:0]
    typedef logic [6:0] opcodeT;

    // minor opcode, instr[14:12]
    typedef logic [2:0] func3T;

    // instr[31:25], sub/sra select in bit 5
    typedef logic [6:0] func7T;

    // architectural register index
    typedef logic [4:0] regIdxT;

    // integer register-register ops
    localparam opcodeT OP_OP     = 7'b011_0011;
    // integer register-immediate ops
    localparam opcodeT OP_OP_IMM = 7'b001_0011;
    // 32-bit register-register ops, result sign-extended
    localparam opcodeT OP_OP_32  = 7'b011_1011;
    // 32-bit register-immediate ops
    localparam opcodeT OP_IMM_32 = 7'b001_1011;
    // load upper immediate
    localparam opcodeT OP_LUI    = 7'b011_0111;
    // pc plus upper immediate
    localparam opcodeT OP_AUIPC  = 7'b001_0111;

    // funct3 codes shared by OP, OP-IMM and the 32-bit forms
    localparam func3T F3OP_ADD_SUB = 3'b000;
    localparam func3T F3OP_SLL     = 3'b001;
    localparam func3T F3OP_SLT     = 3'b010;
    localparam func3T F3OP_SLTU    = 3'b011;
    localparam func3T F3OP_XOR     = 3'b100;
    // srl or sra, picked by funct7
    localparam func3T F3OP_SRX     = 3'b101;
    localparam func3T F3OP_OR      = 3'b110;
    localparam func3T F3OP_AND     = 3'b111;

    // plain form
    localparam func7T F7_BASE = 7'b000_0000;
    // sub and sra
    localparam func7T F7_ALT  = 7'b010_0000;

endpackage

// File: hdl/instrDecode.sv
`timescale 1ns/100ps

module instrDecode (
    input  logic                clk,
    input  logic                rstN,
    input  logic                inValid,
    input  rv64ExecPkg::instrT  instr,
    input  rv64ExecPkg::wordT   pc,
    input  rv64ExecPkg::wordT   rs1Value,
    input  rv64ExecPkg::wordT   rs2Value,
    output rv64ExecPkg::wordT   aOp,
    output rv64ExecPkg::wordT   bOp,
    output rv64ExecPkg::func3T  func3,
    output rv64ExecPkg::func7T  func7,
    output rv64ExecPkg::opcodeT op,
    output rv64ExecPkg::regIdxT decRd,
    output logic                decValid,
    output logic                decIllegal
);

    // raw instruction fields
    rv64ExecPkg::opcodeT opcode;
    rv64ExecPkg::regIdxT rdIdx;
    rv64ExecPkg::func3T  f3;
    rv64ExecPkg::func7T  f7;
    rv64ExecPkg::wordT   immI;
    rv64ExecPkg::wordT   immU;

    // next-state values for the decode registers
    rv64ExecPkg::wordT   aNext;
    rv64ExecPkg::wordT   bNext;
    rv64ExecPkg::func7T  f7Next;
    logic                illegal;

    assign opcode = instr[6:0];
    assign rdIdx  = instr[11:7];
    assign f3     = instr[14:12];
    assign f7     = instr[31:25];

    // I immediate, sign-extended from bit 31
    assign immI = {{52{instr[31]}}, instr[31:20]};
    // U immediate, low 12 bits zero, sign-extended to 64
    assign immU = {{32{instr[31]}}, instr[31:12], 12'b0};

    always_comb begin
        illegal = 1'b0;
        aNext   = rs1Value;
        bNext   = immI;
        // immediate arithmetic has no funct7, keep it neutral for the ALU
        f7Next  = rv64ExecPkg::F7_BASE;
        case (opcode)
            rv64ExecPkg::OP_OP: begin
                bNext  = rs2Value;
                f7Next = f7;
                if (f7 != rv64ExecPkg::F7_BASE && f7 != rv64ExecPkg::F7_ALT)
                    illegal = 1'b1;
                // alt is only sub or sra
                else if (f7 == rv64ExecPkg::F7_ALT && f3 != rv64ExecPkg::F3OP_ADD_SUB
                         && f3 != rv64ExecPkg::F3OP_SRX)
                    illegal = 1'b1;
            end
            rv64ExecPkg::OP_OP_32: begin
                bNext  = rs2Value;
                f7Next = f7;
                // only addw/subw, sllw, srlw/sraw exist
                if (f3 != rv64ExecPkg::F3OP_ADD_SUB && f3 != rv64ExecPkg::F3OP_SLL
                    && f3 != rv64ExecPkg::F3OP_SRX)
                    illegal = 1'b1;
                else if (f7 != rv64ExecPkg::F7_BASE && f7 != rv64ExecPkg::F7_ALT)
                    illegal = 1'b1;
                else if (f7 == rv64ExecPkg::F7_ALT && f3 == rv64ExecPkg::F3OP_SLL)
                    illegal = 1'b1;
            end
            rv64ExecPkg::OP_OP_IMM: begin
                if (f3 == rv64ExecPkg::F3OP_SLL || f3 == rv64ExecPkg::F3OP_SRX) begin
                    // bit 25 is shamt[5] here, not part of funct7
                    f7Next = {f7[6:1], 1'b0};
                    if (f7Next != rv64ExecPkg::F7_BASE && f7Next != rv64ExecPkg::F7_ALT)
                        illegal = 1'b1;
                    else if (f7Next == rv64ExecPkg::F7_ALT && f3 == rv64ExecPkg::F3OP_SLL)
                        illegal = 1'b1;
                end
            end
            rv64ExecPkg::OP_IMM_32: begin
                if (f3 == rv64ExecPkg::F3OP_SLL || f3 == rv64ExecPkg::F3OP_SRX) begin
                    // 5-bit shamt, so bit 25 must stay clear
                    f7Next = f7;
                    if (f7 != rv64ExecPkg::F7_BASE && f7 != rv64ExecPkg::F7_ALT)
                        illegal = 1'b1;
                    else if (f7 == rv64ExecPkg::F7_ALT && f3 == rv64ExecPkg::F3OP_SLL)
                        illegal = 1'b1;
                end
                else if (f3 != rv64ExecPkg::F3OP_ADD_SUB)
                    illegal = 1'b1;
            end
            rv64ExecPkg::OP_LUI: begin
                aNext = '0;
                bNext = immU;
            end
            rv64ExecPkg::OP_AUIPC: begin
                aNext = pc;
                bNext = immU;
            end
            // branches, loads, stores, system and the rest
            default: illegal = 1'b1;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            decValid   <= 1'b0;
            decIllegal <= 1'b0;
            aOp        <= '0;
            bOp        <= '0;
            func3      <= '0;
            func7      <= '0;
            op         <= '0;
            decRd      <= '0;
        end else begin
            decValid <= inValid;
            // hold the previous item between strobes
            if (inValid) begin
                decIllegal <= illegal;
                aOp        <= aNext;
                bOp        <= bNext;
                func3      <= f3;
                func7      <= f7Next;
                op         <= opcode;
                decRd      <= rdIdx;
            end
        end
    end

endmodule

// File: hdl/Alu.sv
`timescale 1ns/100ps

module Alu
(
    // rs1, pc or zero
    input  rv64ExecPkg::wordT   a,
    // rs2 or immediate
    input  rv64ExecPkg::wordT   b,
    input  rv64ExecPkg::func3T  func3,
    input  rv64ExecPkg::func7T  func7,
    input  rv64ExecPkg::opcodeT op,
    output rv64ExecPkg::wordT   result
);

    // sub / sra select
    logic              alt;
    // 6-bit shift for 64-bit ops, 5-bit for word ops
    logic [5:0]        shamt;
    logic [4:0]        shamtW;
    // low halves for the word forms
    logic [31:0]       aW;
    logic [31:0]       bW;
    logic [31:0]       sraW;
    logic [31:0]       resW;
    rv64ExecPkg::wordT sra64;
    rv64ExecPkg::wordT res64;

    assign alt    = func7[5];
    assign shamt  = b[5:0];
    assign shamtW = b[4:0];
    assign aW     = a[31:0];
    assign bW     = b[31:0];

    // arithmetic right shifts for both widths
    assign sra64 = $signed(a) >>> shamt;
    assign sraW  = $signed(aW) >>> shamtW;

    // full-width path for OP and OP-IMM
    always_comb begin
        case (func3)
            rv64ExecPkg::F3OP_ADD_SUB: begin
                // immediates never subtract
                if (alt && op == rv64ExecPkg::OP_OP)
                    res64 = a - b;
                else
                    res64 = a + b;
            end
            rv64ExecPkg::F3OP_SLL:  res64 = a << shamt;
            rv64ExecPkg::F3OP_SLT:  res64 = {63'b0, $signed(a) < $signed(b)};
            rv64ExecPkg::F3OP_SLTU: res64 = {63'b0, a < b};
            rv64ExecPkg::F3OP_XOR:  res64 = a ^ b;
            rv64ExecPkg::F3OP_SRX:  res64 = alt ? sra64 : a >> shamt;
            rv64ExecPkg::F3OP_OR:   res64 = a | b;
            default:                res64 = a & b;
        endcase
    end

    // word path for OP-32 and OP-IMM-32
    always_comb begin
        case (func3)
            rv64ExecPkg::F3OP_SLL: resW = aW << shamtW;
            rv64ExecPkg::F3OP_SRX: resW = alt ? sraW : aW >> shamtW;
            default: begin
                // addw, subw and addiw
                // other funct3 already flagged by decode
                if (alt && op == rv64ExecPkg::OP_OP_32)
                    resW = aW - bW;
                else
                    resW = aW + bW;
            end
        endcase
    end

    // pick by major opcode
    always_comb begin
        case (op)
            rv64ExecPkg::OP_OP,
            rv64ExecPkg::OP_OP_IMM: result = res64;
            rv64ExecPkg::OP_OP_32,
            rv64ExecPkg::OP_IMM_32: result = {{32{resW[31]}}, resW};
            // lui and auipc add zero or pc
            default:                result = a + b;
        endcase
    end

endmodule

// File: hdl/resultStage.sv
`timescale 1ns/100ps

module resultStage (
    input  logic                clk,
    input  logic                rstN,
    input  logic                decValid,
    input  logic                decIllegal,
    input  rv64ExecPkg::regIdxT decRd,
    input  rv64ExecPkg::wordT   result,
    output logic                outValid,
    output logic                outIllegal,
    output rv64ExecPkg::regIdxT outRd,
    output rv64ExecPkg::wordT   outResult
);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            outValid   <= 1'b0;
            outIllegal <= 1'b0;
            outRd      <= '0;
            outResult  <= '0;
        end else begin
            outValid   <= decValid;
            // flag only rides along with a strobe
            outIllegal <= decValid & decIllegal;
            // data holds between items
            if (decValid) begin
                outRd     <= decRd;
                outResult <= result;
            end
        end
    end

endmodule

// File: hdl/execTop.sv
`timescale 1ns/100ps

module execTop (
    input  logic                clk,
    input  logic                rstN,
    input  logic                inValid,
    input  rv64ExecPkg::instrT  instr,
    input  rv64ExecPkg::wordT   pc,
    input  rv64ExecPkg::wordT   rs1Value,
    input  rv64ExecPkg::wordT   rs2Value,
    output logic                outValid,
    output logic                outIllegal,
    output rv64ExecPkg::regIdxT outRd,
    output rv64ExecPkg::wordT   outResult
);

    // decode registers into ALU
    rv64ExecPkg::wordT   aOp;
    rv64ExecPkg::wordT   bOp;
    rv64ExecPkg::func3T  func3;
    rv64ExecPkg::func7T  func7;
    rv64ExecPkg::opcodeT op;
    // decode registers straight to result stage
    rv64ExecPkg::regIdxT decRd;
    logic                decValid;
    logic                decIllegal;
    // combinational ALU output
    rv64ExecPkg::wordT   result;

    // stage 1, decode and operand select
    instrDecode uDecode (
        .clk        (clk),
        .rstN       (rstN),
        .inValid    (inValid),
        .instr      (instr),
        .pc         (pc),
        .rs1Value   (rs1Value),
        .rs2Value   (rs2Value),
        .aOp        (aOp),
        .bOp        (bOp),
        .func3      (func3),
        .func7      (func7),
        .op         (op),
        .decRd      (decRd),
        .decValid   (decValid),
        .decIllegal (decIllegal)
    );

    Alu uAlu (
        .a      (aOp),
        .b      (bOp),
        .func3  (func3),
        .func7  (func7),
        .op     (op),
        .result (result)
    );

    // stage 2, capture and strobe out
    resultStage uResult (
        .clk        (clk),
        .rstN       (rstN),
        .decValid   (decValid),
        .decIllegal (decIllegal),
        .decRd      (decRd),
        .result     (result),
        .outValid   (outValid),
        .outIllegal (outIllegal),
        .outRd      (outRd),
        .outResult  (outResult)
    );

endmodule

// File: test/execTop_chk.sv
`timescale 1ns/100ps

module execTop_chk (
    input logic clk,
    input logic rstN,
    input logic inValid,
    input logic outValid,
    input logic outIllegal
);

    // fixed two-stage pipe, in both directions
    assert property (@(posedge clk) disable iff (!rstN) inValid |-> ##2 outValid)
        else $error("inValid not followed by outValid two cycles later");
    assert property (@(posedge clk) disable iff (!rstN) outValid |-> $past(inValid, 2))
        else $error("outValid without inValid two cycles earlier");

    // pipe must come out of reset empty
    assert property (@(posedge clk) $rose(rstN) |-> !outValid)
        else $error("outValid high right after reset release");

    // flag only travels with a strobe
    assert property (@(posedge clk) disable iff (!rstN) outIllegal |-> outValid)
        else $error("outIllegal high without outValid");

endmodule

bind execTop execTop_chk uChk (
    .clk        (clk),
    .rstN       (rstN),
    .inValid    (inValid),
    .outValid   (outValid),
    .outIllegal (outIllegal)
);

// File: test/execTopTb.sv
`timescale 1ns/100ps

module execTopTb;

    // one stimulus item with its expected response
    typedef struct packed {
        rv64ExecPkg::instrT  instr;
        rv64ExecPkg::wordT   pc, rs1, rs2, res;
        rv64ExecPkg::regIdxT rd;
        logic                ill;
    } entryT;

    // short names for the opcodes used in the table
    localparam rv64ExecPkg::opcodeT OPR     = rv64ExecPkg::OP_OP;
    localparam rv64ExecPkg::opcodeT OPI     = rv64ExecPkg::OP_OP_IMM;
    localparam rv64ExecPkg::opcodeT OPW     = rv64ExecPkg::OP_OP_32;
    localparam rv64ExecPkg::opcodeT OPIW    = rv64ExecPkg::OP_IMM_32;
    localparam rv64ExecPkg::opcodeT OPLUI   = rv64ExecPkg::OP_LUI;
    localparam rv64ExecPkg::opcodeT OPAUIPC = rv64ExecPkg::OP_AUIPC;
    localparam rv64ExecPkg::func7T  F7B     = rv64ExecPkg::F7_BASE;
    localparam rv64ExecPkg::func7T  F7A     = rv64ExecPkg::F7_ALT;
    localparam rv64ExecPkg::wordT   MSB     = 64'h8000_0000_0000_0000;

    logic                clk = 1'b0;
    logic                rstN;
    logic                inValid;
    rv64ExecPkg::instrT  instr;
    rv64ExecPkg::wordT   pc;
    rv64ExecPkg::wordT   rs1Value;
    rv64ExecPkg::wordT   rs2Value;
    logic                outValid;
    logic                outIllegal;
    rv64ExecPkg::regIdxT outRd;
    rv64ExecPkg::wordT   outResult;

    entryT       vectors[$];
    entryT       pending[$];
    // edge at which the DUT sampled each pending item
    int          issued[$];
    int          cycle = 0;
    int          limit;
    int          nDone = 0;
    logic [31:0] lcgState;

    execTop UUT (
        .clk        (clk),
        .rstN       (rstN),
        .inValid    (inValid),
        .instr      (instr),
        .pc         (pc),
        .rs1Value   (rs1Value),
        .rs2Value   (rs2Value),
        .outValid   (outValid),
        .outIllegal (outIllegal),
        .outRd      (outRd),
        .outResult  (outResult)
    );

    always #2 clk = ~clk;

    // instruction encoders
    // rs1 and rs2 fields are don't care for the DUT
    function automatic rv64ExecPkg::instrT rType(input rv64ExecPkg::func7T f7,
            input rv64ExecPkg::func3T f3, input rv64ExecPkg::opcodeT opc,
            input rv64ExecPkg::regIdxT rd);
        return {f7, 5'd2, 5'd1, f3, rd, opc};
    endfunction

    function automatic rv64ExecPkg::instrT iType(input logic [11:0] imm,
            input rv64ExecPkg::func3T f3, input rv64ExecPkg::opcodeT opc,
            input rv64ExecPkg::regIdxT rd);
        return {imm, 5'd1, f3, rd, opc};
    endfunction

    function automatic rv64ExecPkg::instrT uType(input logic [19:0] imm,
            input rv64ExecPkg::opcodeT opc, input rv64ExecPkg::regIdxT rd);
        return {imm, rd, opc};
    endfunction

    function automatic logic [31:0] nextRand();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    // reference for the random mix
    // kind 0 add, 1 xor, 2 sltu, 3 sraw
    function automatic rv64ExecPkg::wordT refOp(input int kind, input rv64ExecPkg::wordT a,
            input rv64ExecPkg::wordT b);
        rv64ExecPkg::wordT wide;
        case (kind)
            0: return a + b;
            1: return a ^ b;
            2: return (a < b) ? 64'd1 : 64'd0;
            default: begin
                // a shift below 32 keeps the sign-extended low word extended
                wide = {{32{a[31]}}, a[31:0]};
                return $signed(wide) >>> b[4:0];
            end
        endcase
    endfunction

    task automatic addEntry(input rv64ExecPkg::instrT i, input rv64ExecPkg::wordT p,
            input rv64ExecPkg::wordT a, input rv64ExecPkg::wordT b,
            input rv64ExecPkg::wordT r, input rv64ExecPkg::regIdxT d, input logic ill);
        vectors.push_back({i, p, a, b, r, d, ill});
    endtask

    task automatic reportError(input string msg);
        $display("ERR %0t: %s", $time, msg);
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic checkWord(input rv64ExecPkg::wordT got, input rv64ExecPkg::wordT exp,
            input string what);
        if (got !== exp)
            reportError($sformatf("%s got %h, expected %h", what, got, exp));
    endtask

    task automatic checkRd(input rv64ExecPkg::regIdxT got, input rv64ExecPkg::regIdxT exp,
            input string what);
        if (got !== exp)
            reportError($sformatf("%s got %0d, expected %0d", what, got, exp));
    endtask

    task automatic checkFlag(input logic got, input logic exp, input string what);
        if (got !== exp)
            reportError($sformatf("%s got %b, expected %b", what, got, exp));
    endtask

    initial begin : stimulus
        logic [31:0]         r;
        int                  kind;
        rv64ExecPkg::wordT   a;
        rv64ExecPkg::wordT   b;
        rv64ExecPkg::regIdxT rd;
        rv64ExecPkg::instrT  ins;
        rstN     = 1'b0;
        inValid  = 1'b0;
        instr    = '0;
        pc       = '0;
        rs1Value = '0;
        rs2Value = '0;
        lcgState = 32'd36;

        // 64-bit register ops
        addEntry(rType(F7B, 0, OPR, 1), 0, 64'h7FFF_FFFF_FFFF_FFFF, 1, MSB, 1, 0);
        addEntry(rType(F7A, 0, OPR, 2), 0, 5, 7, -2, 2, 0);
        addEntry(rType(F7B, 1, OPR, 3), 0, 1, 63, MSB, 3, 0);
        addEntry(rType(F7B, 2, OPR, 4), 0, -1, 1, 1, 4, 0);
        addEntry(rType(F7B, 3, OPR, 5), 0, -1, 1, 0, 5, 0);
        addEntry(rType(F7B, 4, OPR, 6), 0, 64'hFF00_FF00_FF00_FF00, -1,
                 64'h00FF_00FF_00FF_00FF, 6, 0);
        addEntry(rType(F7B, 5, OPR, 7), 0, MSB, 63, 1, 7, 0);
        addEntry(rType(F7A, 5, OPR, 8), 0, MSB, 63, -1, 8, 0);
        // only rs2[5:0] counts so 0x43 shifts by 3
        addEntry(rType(F7A, 5, OPR, 9), 0, -16, 64'h43, -2, 9, 0);
        addEntry(rType(F7B, 6, OPR, 10), 0, 64'hF0, 64'h0F, 64'hFF, 10, 0);
        addEntry(rType(F7B, 7, OPR, 11), 0, 64'hFFFF_0000_FFFF_0000,
                 64'h1234_5678_9ABC_DEF0, 64'h1234_0000_9ABC_0000, 11, 0);
        // immediates ignore the junk rs2
        addEntry(iType(12'hFFF, 0, OPI, 12), 0, 10, 64'hDEAD, 9, 12, 0);
        addEntry(iType(12'h800, 0, OPI, 13), 0, 0, 64'hDEAD, 64'hFFFF_FFFF_FFFF_F800, 13, 0);
        addEntry(iType(12'hFFF, 3, OPI, 14), 0, 5, 0, 1, 14, 0);
        // shamt 33 and 40 with bit 25 as shamt[5]
        addEntry(iType(12'h021, 1, OPI, 15), 0, 1, 0, 64'h0000_0002_0000_0000, 15, 0);
        addEntry(iType(12'h428, 5, OPI, 16), 0, MSB, 0, 64'hFFFF_FFFF_FF80_0000, 16, 0);
        // word ops with 5-bit shifts and sign-extended results
        addEntry(rType(F7B, 0, OPW, 17), 0, 64'h7FFF_FFFF, 1, 64'hFFFF_FFFF_8000_0000, 17, 0);
        addEntry(rType(F7A, 0, OPW, 18), 0, 64'h1_0000_0000, 1, -1, 18, 0);
        addEntry(rType(F7B, 1, OPW, 19), 0, 1, 64'h3F, 64'hFFFF_FFFF_8000_0000, 19, 0);
        addEntry(rType(F7B, 5, OPW, 20), 0, 64'hFFFF_FFFF_8000_0000, 31, 1, 20, 0);
        addEntry(rType(F7A, 5, OPW, 21), 0, 64'h8000_0000, 4, 64'hFFFF_FFFF_F800_0000, 21, 0);
        addEntry(iType(12'hFFF, 0, OPIW, 22), 0, 64'h1_0000_0000, 0, -1, 22, 0);
        addEntry(iType(12'h41F, 5, OPIW, 23), 0, 64'h8000_0000, 0, -1, 23, 0);
        // lui ignores rs1
        addEntry(uType(20'h80000, OPLUI, 24), 0, 64'h1234, 0, 64'hFFFF_FFFF_8000_0000, 24, 0);
        // auipc with a negative offset
        addEntry(uType(20'hFFFFF, OPAUIPC, 25), 64'h1_0000, 0, 0, 64'hF000, 25, 0);
        // illegal branch, mul, alt on xor and slt on OP-32
        addEntry(rType(F7B, 0, 7'b110_0011, 26), 0, 1, 1, 0, 26, 1);
        addEntry(rType(7'b000_0001, 0, OPR, 27), 0, 1, 1, 0, 27, 1);
        addEntry(rType(F7A, 4, OPR, 28), 0, 1, 1, 0, 28, 1);
        addEntry(rType(F7B, 2, OPW, 29), 0, 1, 1, 0, 29, 1);

        // random tail
        for (int n = 0; n < 64; n++) begin
            r    = nextRand();
            kind = r[17:16];
            rd   = r[12:8];
            a    = {nextRand(), nextRand()};
            b    = {nextRand(), nextRand()};
            case (kind)
                0: ins = rType(F7B, 0, OPR, rd);
                1: ins = rType(F7B, 4, OPR, rd);
                2: ins = rType(F7B, 3, OPR, rd);
                default: ins = rType(F7A, 5, OPW, rd);
            endcase
            addEntry(ins, 0, a, b, refOp(kind, a, b), rd, 0);
        end
        limit = vectors.size() + 20;

        repeat (4) @(posedge clk);
        rstN <= 1'b1;
        // one item per cycle with no gaps
        for (int i = 0; i < vectors.size(); i++) begin
            @(posedge clk);
            inValid  <= 1'b1;
            instr    <= vectors[i].instr;
            pc       <= vectors[i].pc;
            rs1Value <= vectors[i].rs1;
            rs2Value <= vectors[i].rs2;
            pending.push_back(vectors[i]);
            // DUT samples it on the next edge
            issued.push_back(cycle + 1);
        end
        @(posedge clk);
        inValid <= 1'b0;
        while (pending.size() != 0)
            @(posedge clk);
        // catch stray strobes
        repeat (3) @(posedge clk);
        $display("Everything OK");
        $finish;
    end

    always @(posedge clk) begin : monitor
        entryT e;
        int    iss;
        if (outValid === 1'b1) begin
            if (pending.size() == 0) begin
                $display("outValid pulsed while no item was in flight");
                $display("Something failed");
                $fatal(1);
            end else begin
                e   = pending.pop_front();
                iss = issued.pop_front();
                if (cycle != iss + 2)
                    reportError($sformatf("item %0d latency %0d", nDone, cycle - iss));
                checkFlag(outIllegal, e.ill, $sformatf("item %0d outIllegal", nDone));
                checkRd(outRd, e.rd, $sformatf("item %0d outRd", nDone));
                // result is unspecified on illegal items
                if (!e.ill)
                    checkWord(outResult, e.res, $sformatf("item %0d outResult", nDone));
                nDone = nDone + 1;
            end
        end else if (outIllegal === 1'b1) begin
            reportError("outIllegal high without outValid");
        end
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= limit) begin
            $display("timeout after %0d cycles with %0d items still pending",
                     cycle, pending.size());
            $display("Something failed");
            $fatal(1);
        end
    end

endmodule

// File: project.f
hdl/rv64ExecPkg.sv
hdl/instrDecode.sv
hdl/Alu.sv
hdl/resultStage.sv
hdl/execTop.sv
test/execTop_chk.sv
test/execTopTb.sv

// File: Bender.yml
package:
  name: rv64_exec

sources:
  - hdl/rv64ExecPkg.sv
  - hdl/instrDecode.sv
  - hdl/Alu.sv
  - hdl/resultStage.sv
  - hdl/execTop.sv
  - target: test
    files:
      - test/execTop_chk.sv
      - test/execTopTb.sv
